// File: design/ecc_pkg.sv
//######################################
// Fixed build of 8 beats of 64 data bits with 8 check bits per beat
// H matrix is a constant, derived at elaboration from weight-3/5 columns
//######################################

package ecc_pkg;

  // Beats carried by one controller clock
  localparam int BEATS = 8;

  // Per-beat widths
  localparam int DATA_WIDTH    = 64;
  localparam int DATA_BYTES    = DATA_WIDTH / 8;
  localparam int PAYLOAD_WIDTH = 64;
  localparam int ECC_WIDTH     = 8;
  localparam int CODE_WIDTH    = 72;
  localparam int DQ_WIDTH      = 72;

  // Columns of the H matrix that cover data bits
  localparam int DATA_COLS = CODE_WIDTH - ECC_WIDTH;

  // Row k of the matrix selects the code bits that feed check bit k
  typedef logic [ECC_WIDTH-1:0][CODE_WIDTH-1:0] h_matrix_t;

  // Number of set bits in one column pattern
  function automatic int bit_weight(input logic [ECC_WIDTH-1:0] pattern);
    int count;
    count = 0;
    for (int i = 0; i < ECC_WIDTH; i++) begin
      if (pattern[i]) begin
        count++;
      end
    end
    return count;
  endfunction

  // Write one column pattern into the matrix
  function automatic h_matrix_t set_column(
    input h_matrix_t            rows,
    input int                   col,
    input logic [ECC_WIDTH-1:0] pattern
  );
    h_matrix_t result;
    result = rows;
    for (int k = 0; k < ECC_WIDTH; k++) begin
      result[k][col] = pattern[k];
    end
    return result;
  endfunction

  // Hsiao-style matrix construction
  // Data columns take the odd-weight patterns in ascending order,
  // all weight 3 first and then weight 5 until the data columns are full
  function automatic h_matrix_t make_h_rows();
    h_matrix_t            rows;
    logic [ECC_WIDTH-1:0] pattern;
    int                   col;
    rows = '0;
    col  = 0;
    for (int weight = 3; weight <= 5; weight += 2) begin
      for (int value = 0; value < (1 << ECC_WIDTH); value++) begin
        pattern = ECC_WIDTH'(value);
        if (bit_weight(pattern) == weight && col < DATA_COLS) begin
          rows = set_column(rows, col, pattern);
          col++;
        end
      end
    end

    // Check bit k sits at code bit CODE_WIDTH-1-k with a unit column
    for (int k = 0; k < ECC_WIDTH; k++) begin
      rows[k][CODE_WIDTH-1-k] = 1'b1;
    end
    return rows;
  endfunction

  // Constant matrix shared by the encoder
  localparam h_matrix_t h_rows = make_h_rows();

endpackage

// File: design/wr_byte_merge.sv
//######################################
// Mask bit set means the byte comes from read-back data
// Payload bits above DATA_WIDTH pass through from wr_data
//######################################

module wr_byte_merge import ecc_pkg::*; (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             wr_data_en,
  input  logic [BEATS*PAYLOAD_WIDTH-1:0]   wr_data,
  input  logic [BEATS*DATA_BYTES-1:0]      wr_data_mask,
  input  logic [BEATS*DATA_WIDTH-1:0]      rd_merge_data,
  input  logic [BEATS-1:0]                 raw_not_ecc,
  output logic                             merge_en,
  output logic [BEATS*PAYLOAD_WIDTH-1:0]   merged_data,
  output logic [BEATS-1:0]                 merge_raw
);

  logic [BEATS*PAYLOAD_WIDTH-1:0] merge_next;

  // Byte select per beat
  always_comb begin
    // Start from the write payload so any upper payload bits survive
    merge_next = wr_data;
    for (int beat = 0; beat < BEATS; beat++) begin
      for (int byte_idx = 0; byte_idx < DATA_BYTES; byte_idx++) begin
        if (wr_data_mask[beat*DATA_BYTES + byte_idx]) begin
          merge_next[beat*PAYLOAD_WIDTH + byte_idx*8 +: 8] =
            rd_merge_data[beat*DATA_WIDTH + byte_idx*8 +: 8];
        end
      end
    end
  end

  // Strobe for the next stage
  always_ff @(posedge clk) begin
    if (reset) begin
      merge_en <= 1'b0;
    end else begin
      merge_en <= wr_data_en;
    end
  end

  // Merged payload and raw flags travel together
  always_ff @(posedge clk) begin
    if (wr_data_en) begin
      merged_data <= merge_next;
      merge_raw   <= raw_not_ecc;
    end
  end

endmodule

// File: design/ecc_check_gen.sv
//######################################
// Check bit k lands at code bit CODE_WIDTH-1-k
// Raw beats get all-zero check bits
//######################################

module ecc_check_gen import ecc_pkg::*; (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             merge_en,
  input  logic [BEATS*PAYLOAD_WIDTH-1:0]   merged_data,
  input  logic [BEATS-1:0]                 merge_raw,
  output logic                             code_en,
  output logic [BEATS*CODE_WIDTH-1:0]      code_word
);

  logic [PAYLOAD_WIDTH-1:0]        payload;
  logic [ECC_WIDTH-1:0]            check_bits;
  logic [BEATS*CODE_WIDTH-1:0]     code_next;

  // Per-beat encode
  always_comb begin
    // Zero default also clears any gap between payload and check bits
    code_next  = '0;
    payload    = '0;
    check_bits = '0;
    for (int beat = 0; beat < BEATS; beat++) begin
      payload = merged_data[beat*PAYLOAD_WIDTH +: PAYLOAD_WIDTH];
      for (int k = 0; k < ECC_WIDTH; k++) begin
        // Only the data part of each row contributes
        check_bits[k] = ^(payload[DATA_WIDTH-1:0] & h_rows[k][DATA_WIDTH-1:0]);
      end
      if (merge_raw[beat]) begin
        check_bits = '0;
      end

      code_next[beat*CODE_WIDTH +: PAYLOAD_WIDTH] = payload;
      for (int k = 0; k < ECC_WIDTH; k++) begin
        code_next[beat*CODE_WIDTH + CODE_WIDTH-1-k] = check_bits[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      code_en <= 1'b0;
    end else begin
      code_en <= merge_en;
    end
  end

  // Code words load only on a valid merge
  always_ff @(posedge clk) begin
    if (merge_en) begin
      code_word <= code_next;
    end
  end

endmodule

// File: design/dq_lane_pack.sv
//######################################
// Lane bits above CODE_WIDTH are driven zero
//######################################

module dq_lane_pack import ecc_pkg::*; (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          code_en,
  input  logic [BEATS*CODE_WIDTH-1:0]   code_word,
  output logic                          mc_wrdata_en,
  output logic [BEATS*DQ_WIDTH-1:0]     mc_wrdata
);

  logic [BEATS*DQ_WIDTH-1:0] lane_next;

  // Each code word fills the bottom of its lane group
  always_comb begin
    lane_next = '0;
    for (int beat = 0; beat < BEATS; beat++) begin
      lane_next[beat*DQ_WIDTH +: CODE_WIDTH] = code_word[beat*CODE_WIDTH +: CODE_WIDTH];
    end
  end

  // Write strobe toward the memory controller
  always_ff @(posedge clk) begin
    if (reset) begin
      mc_wrdata_en <= 1'b0;
    end else begin
      mc_wrdata_en <= code_en;
    end
  end

  // Holds the last word while the strobe is low
  always_ff @(posedge clk) begin
    if (code_en) begin
      mc_wrdata <= lane_next;
    end
  end

endmodule

// File: design/ecc_merge_enc.sv
//######################################
// Fixed three-cycle latency from inputs to mc_wrdata, no back-pressure
//######################################

module ecc_merge_enc import ecc_pkg::*; (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             wr_data_en,
  input  logic [BEATS*PAYLOAD_WIDTH-1:0]   wr_data,
  input  logic [BEATS*DATA_BYTES-1:0]      wr_data_mask,
  input  logic [BEATS*DATA_WIDTH-1:0]      rd_merge_data,
  input  logic [BEATS-1:0]                 raw_not_ecc,
  output logic                             mc_wrdata_en,
  output logic [BEATS*DQ_WIDTH-1:0]        mc_wrdata
);

  logic                           merge_en;
  logic [BEATS*PAYLOAD_WIDTH-1:0] merged_data;
  logic [BEATS-1:0]               merge_raw;
  logic                           code_en;
  logic [BEATS*CODE_WIDTH-1:0]    code_word;

  // Stage 1 merges masked bytes
  wr_byte_merge u_merge (
    .clk           (clk),
    .reset         (reset),
    .wr_data_en    (wr_data_en),
    .wr_data       (wr_data),
    .wr_data_mask  (wr_data_mask),
    .rd_merge_data (rd_merge_data),
    .raw_not_ecc   (raw_not_ecc),
    .merge_en      (merge_en),
    .merged_data   (merged_data),
    .merge_raw     (merge_raw)
  );

  // Stage 2 adds check bits
  ecc_check_gen u_check (
    .clk         (clk),
    .reset       (reset),
    .merge_en    (merge_en),
    .merged_data (merged_data),
    .merge_raw   (merge_raw),
    .code_en     (code_en),
    .code_word   (code_word)
  );

  // Stage 3 maps code words onto DQ lanes
  dq_lane_pack u_pack (
    .clk          (clk),
    .reset        (reset),
    .code_en      (code_en),
    .code_word    (code_word),
    .mc_wrdata_en (mc_wrdata_en),
    .mc_wrdata    (mc_wrdata)
  );

endmodule

// File: include/ecc_ref_model.svh
//######################################
// Reference model, included inside the testbench module
// Needs the ecc_pkg widths visible where it is included
//######################################

`ifndef ECC_REF_MODEL_SVH
`define ECC_REF_MODEL_SVH

// Data-bit columns of the H matrix, indexed by data bit
logic [DATA_WIDTH-1:0][ECC_WIDTH-1:0] ref_cols;

// Weight-3 patterns in ascending order, then the weight-5 ones
function automatic logic [DATA_WIDTH-1:0][ECC_WIDTH-1:0] build_ref_columns();
  logic [DATA_WIDTH-1:0][ECC_WIDTH-1:0] cols;
  int                                   n;
  cols = '0;
  n    = 0;
  for (int w = 3; w <= 5; w += 2) begin
    for (int v = 0; v < (1 << ECC_WIDTH); v++) begin
      if ($countones(v) == w && n < DATA_WIDTH) begin
        cols[n] = ECC_WIDTH'(v);
        n++;
      end
    end
  end
  return cols;
endfunction

// A set mask bit takes the read-back byte
function automatic logic [PAYLOAD_WIDTH-1:0] ref_merge_beat(
  input logic [PAYLOAD_WIDTH-1:0] data,
  input logic [DATA_BYTES-1:0]    mask,
  input logic [DATA_WIDTH-1:0]    rd
);
  logic [PAYLOAD_WIDTH-1:0] merged;
  merged = data;
  for (int b = 0; b < DATA_BYTES; b++) begin
    if (mask[b]) begin
      merged[b*8 +: 8] = rd[b*8 +: 8];
    end
  end
  return merged;
endfunction

// Each set data bit flips the check bits named by its column
function automatic logic [ECC_WIDTH-1:0] ref_check_bits(input logic [DATA_WIDTH-1:0] data);
  logic [ECC_WIDTH-1:0] check;
  check = '0;
  for (int j = 0; j < DATA_WIDTH; j++) begin
    if (data[j]) begin
      check ^= ref_cols[j];
    end
  end
  return check;
endfunction

// Check bit k of one lane sits at bit CODE_WIDTH-1-k
function automatic logic [ECC_WIDTH-1:0] lane_check_bits(input logic [DQ_WIDTH-1:0] lane);
  logic [ECC_WIDTH-1:0] check;
  for (int k = 0; k < ECC_WIDTH; k++) begin
    check[k] = lane[CODE_WIDTH-1-k];
  end
  return check;
endfunction

// Controller write word expected for one transfer
function automatic logic [BEATS*DQ_WIDTH-1:0] ref_expected_word(
  input logic [BEATS*PAYLOAD_WIDTH-1:0] data,
  input logic [BEATS*DATA_BYTES-1:0]    mask,
  input logic [BEATS*DATA_WIDTH-1:0]    rd,
  input logic [BEATS-1:0]               raw
);
  logic [BEATS*DQ_WIDTH-1:0] word;
  logic [PAYLOAD_WIDTH-1:0]  payload;
  logic [ECC_WIDTH-1:0]      check;
  word = '0;
  for (int beat = 0; beat < BEATS; beat++) begin
    payload = ref_merge_beat(data[beat*PAYLOAD_WIDTH +: PAYLOAD_WIDTH],
                             mask[beat*DATA_BYTES +: DATA_BYTES],
                             rd[beat*DATA_WIDTH +: DATA_WIDTH]);
    check = raw[beat] ? '0 : ref_check_bits(payload[DATA_WIDTH-1:0]);
    word[beat*DQ_WIDTH +: PAYLOAD_WIDTH] = payload;
    for (int k = 0; k < ECC_WIDTH; k++) begin
      word[beat*DQ_WIDTH + CODE_WIDTH-1-k] = check[k];
    end
  end
  return word;
endfunction

`endif

// File: sim/tb_ecc_merge_enc.sv
//######################################
// Fixed-seed LCG stimulus, at most one transfer per cycle
// Expects the fixed three-cycle latency of the write-data path
//######################################

module tb_ecc_merge_enc import ecc_pkg::*; ();

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 5;
  localparam int LATENCY         = 3;
  localparam int STROBE_CYCLES   = 16;
  localparam int MASK_CYCLES     = 8;
  localparam int RAW_CYCLES      = 12;
  localparam int RANDOM_CYCLES   = 240;
  localparam int DISTANCE_PAIRS  = 10;
  localparam int DRAIN_CYCLES    = 6;
  localparam int MARGIN_CYCLES   = 40;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + STROBE_CYCLES + 2*MASK_CYCLES + RAW_CYCLES
                                   + RANDOM_CYCLES + 3*DISTANCE_PAIRS + DRAIN_CYCLES
                                   + LATENCY + MARGIN_CYCLES;

  // Data bits below this index have weight-3 columns, the rest weight 5
  localparam int WEIGHT3_COLS    = ECC_WIDTH * (ECC_WIDTH-1) * (ECC_WIDTH-2) / 6;

  // Isolated enables around a back-to-back run of six, sent from bit 0 up
  localparam logic [STROBE_CYCLES-1:0] strobe_pattern = 16'b0010_0101_1111_1001;

  bit                             clk;
  logic                           reset;
  logic                           wr_data_en;
  logic [BEATS*PAYLOAD_WIDTH-1:0] wr_data;
  logic [BEATS*DATA_BYTES-1:0]    wr_data_mask;
  logic [BEATS*DATA_WIDTH-1:0]    rd_merge_data;
  logic [BEATS-1:0]               raw_not_ecc;
  logic                           mc_wrdata_en;
  logic [BEATS*DQ_WIDTH-1:0]      mc_wrdata;

  logic [31:0] lcg_state = 32'hd77f5322;

  // One entry per accepted transfer, in input order
  logic [BEATS*DQ_WIDTH-1:0]       exp_words[$];
  string                           exp_names[$];
  bit                              exp_distance[$];
  logic [BEATS-1:0][ECC_WIDTH-1:0] exp_weight[$];
  int                              words_sent;
  int                              words_seen;

  // Input enables of the last three cycles
  logic [LATENCY-1:0]        en_pipe = '0;
  logic [BEATS*DQ_WIDTH-1:0] last_word;
  bit                        have_word;

  `include "ecc_ref_model.svh"

  ecc_merge_enc dut (
    .clk           (clk),
    .reset         (reset),
    .wr_data_en    (wr_data_en),
    .wr_data       (wr_data),
    .wr_data_mask  (wr_data_mask),
    .rd_merge_data (rd_merge_data),
    .raw_not_ecc   (raw_not_ecc),
    .mc_wrdata_en  (mc_wrdata_en),
    .mc_wrdata     (mc_wrdata)
  );

  initial begin
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [BEATS*DATA_WIDTH-1:0] random_data();
    logic [BEATS*DATA_WIDTH-1:0] value;
    for (int i = 0; i < BEATS*DATA_WIDTH/32; i++) begin
      value[i*32 +: 32] = next_random();
    end
    return value;
  endfunction

  function automatic logic [BEATS*DATA_BYTES-1:0] random_mask();
    return (BEATS*DATA_BYTES)'({next_random(), next_random()});
  endfunction

  // Drives one cycle and queues the expected word when enabled
  task automatic send_transfer(
    input string                           name,
    input logic                            en,
    input logic [BEATS*PAYLOAD_WIDTH-1:0]  data,
    input logic [BEATS*DATA_BYTES-1:0]     mask,
    input logic [BEATS*DATA_WIDTH-1:0]     rd,
    input logic [BEATS-1:0]                raw,
    input bit                              distance,
    input logic [BEATS-1:0][ECC_WIDTH-1:0] weight
  );
    @(posedge clk);
    wr_data_en    <= en;
    wr_data       <= data;
    wr_data_mask  <= mask;
    rd_merge_data <= rd;
    raw_not_ecc   <= raw;
    if (en) begin
      exp_words.push_back(ref_expected_word(data, mask, rd, raw));
      exp_names.push_back(name);
      exp_distance.push_back(distance);
      exp_weight.push_back(weight);
      words_sent++;
    end
  endtask

  // Idle cycle with fresh data that must not load
  task automatic send_idle();
    send_transfer("hold", 1'b0, random_data(), random_mask(), random_data(),
                  BEATS'(next_random() >> 8), 1'b0, '0);
  endtask

  task automatic run_strobe_test();
    for (int i = 0; i < STROBE_CYCLES; i++) begin
      send_transfer("strobe_timing", strobe_pattern[i], random_data(), random_mask(),
                    random_data(), '0, 1'b0, '0);
    end
  endtask

  task automatic run_mask_tests();
    for (int i = 0; i < MASK_CYCLES; i++) begin
      send_transfer("mask_zero", 1'b1, random_data(), '0, random_data(), '0, 1'b0, '0);
    end
    for (int i = 0; i < MASK_CYCLES; i++) begin
      send_transfer("mask_ones", 1'b1, random_data(), '1, random_data(), '0, 1'b0, '0);
    end
  endtask

  // First transfer fully raw, the rest mix raw and encoded beats
  task automatic run_raw_test();
    logic [BEATS-1:0] raw;
    for (int i = 0; i < RAW_CYCLES; i++) begin
      raw = (i == 0) ? '1 : BEATS'(next_random() >> 12);
      send_transfer("raw_mode", 1'b1, random_data(), random_mask(), random_data(), raw,
                    1'b0, '0);
    end
  endtask

  // About three quarters of the cycles carry a transfer
  task automatic run_random_test();
    logic [31:0] r;
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      r = next_random();
      send_transfer("random_mix", r[31:30] != 2'b00, random_data(), random_mask(),
                    random_data(), BEATS'(next_random() >> 8), 1'b0, '0);
    end
  endtask

  // Pairs of ECC transfers one payload bit apart in every beat
  task automatic run_distance_test();
    logic [BEATS*PAYLOAD_WIDTH-1:0]  base;
    logic [BEATS*PAYLOAD_WIDTH-1:0]  flipped;
    logic [BEATS-1:0][ECC_WIDTH-1:0] weight;
    logic [31:0]                     r;
    int                              pos;
    for (int p = 0; p < DISTANCE_PAIRS; p++) begin
      base    = random_data();
      flipped = base;
      for (int beat = 0; beat < BEATS; beat++) begin
        r   = next_random();
        pos = int'(r[31:16]) % DATA_WIDTH;
        flipped[beat*PAYLOAD_WIDTH + pos] = ~flipped[beat*PAYLOAD_WIDTH + pos];
        weight[beat] = (pos < WEIGHT3_COLS) ? ECC_WIDTH'(3) : ECC_WIDTH'(5);
      end
      send_transfer("single_bit_distance", 1'b1, base, '0, random_data(), '0, 1'b0, '0);
      send_transfer("single_bit_distance", 1'b1, flipped, '0, random_data(), '0, 1'b1,
                    weight);
      send_idle();
    end
  endtask

  // Outputs are sampled on the falling edge, away from the drive edge
  always @(negedge clk) begin : check_outputs
    logic                            exp_en;
    logic [BEATS*DQ_WIDTH-1:0]       exp_word;
    logic [BEATS-1:0][ECC_WIDTH-1:0] weight_exp;
    logic [ECC_WIDTH-1:0]            delta;
    string                           name;
    bit                              distance;

    exp_en  = en_pipe[LATENCY-1];
    en_pipe = {en_pipe[LATENCY-2:0], wr_data_en};
    assert (mc_wrdata_en === exp_en) else begin
      $display("[FAIL] strobe_timing: expected %b, actual %b", exp_en, mc_wrdata_en);
      $display("Simulation failed");
      $fatal(1, "write strobe out of step");
    end

    if (exp_en) begin
      assert (exp_words.size() != 0) else begin
        $display("An output word came out with no transfer waiting for it");
        $display("Simulation failed");
        $fatal(1, "unexpected output word");
      end
      exp_word   = exp_words.pop_front();
      name       = exp_names.pop_front();
      distance   = exp_distance.pop_front();
      weight_exp = exp_weight.pop_front();
      for (int beat = 0; beat < BEATS; beat++) begin
        assert (mc_wrdata[beat*DQ_WIDTH +: DQ_WIDTH] === exp_word[beat*DQ_WIDTH +: DQ_WIDTH])
        else begin
          $display("[FAIL] %s beat %0d: expected %h, actual %h", name, beat,
                   exp_word[beat*DQ_WIDTH +: DQ_WIDTH], mc_wrdata[beat*DQ_WIDTH +: DQ_WIDTH]);
          $display("Simulation failed");
          $fatal(1, "lane mismatch");
        end
        if (distance) begin
          delta = lane_check_bits(mc_wrdata[beat*DQ_WIDTH +: DQ_WIDTH])
                ^ lane_check_bits(last_word[beat*DQ_WIDTH +: DQ_WIDTH]);
          assert ($countones(delta) == int'(weight_exp[beat])) else begin
            $display("[FAIL] %s beat %0d: expected weight %0d, actual weight %0d", name,
                     beat, weight_exp[beat], $countones(delta));
            $display("Simulation failed");
            $fatal(1, "check-bit distance mismatch");
          end
        end
      end
      last_word = mc_wrdata;
      have_word = 1'b1;
      words_seen++;
    end else if (have_word) begin
      assert (mc_wrdata === last_word) else begin
        $display("[FAIL] hold: expected %h, actual %h", last_word, mc_wrdata);
        $display("Simulation failed");
        $fatal(1, "write word changed while idle");
      end
    end
  end

  initial begin
    reset         = 1'b1;
    wr_data_en    = 1'b0;
    wr_data       = '0;
    wr_data_mask  = '0;
    rd_merge_data = '0;
    raw_not_ecc   = '0;
    ref_cols      = build_ref_columns();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    run_strobe_test();
    run_mask_tests();
    run_raw_test();
    run_random_test();
    run_distance_test();

    while (exp_words.size() != 0) begin
      send_idle();
    end
    repeat (DRAIN_CYCLES) send_idle();

    if (words_seen == words_sent && words_sent > 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Sent %0d transfers but checked %0d words", words_sent, words_seen);
      $display("Simulation failed");
      $fatal(1, "transfer count mismatch");
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $fatal(1, "watchdog timeout");
  end

endmodule

// File: ecc_merge_enc.f
+incdir+include
design/ecc_pkg.sv
design/wr_byte_merge.sv
design/ecc_check_gen.sv
design/dq_lane_pack.sv
design/ecc_merge_enc.sv
sim/tb_ecc_merge_enc.sv

// File: Makefile
# Verilator build and run of the ECC write-data path testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_ecc_merge_enc
FILELIST  := ecc_merge_enc.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_TEXT := Simulation passed

SOURCES   := $(shell grep -v '^+' $(FILELIST)) include/ecc_ref_model.svh

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, since tee hides the simulator exit status
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
	  echo "Result: PASS"; \
	else \
	  echo "Result: FAIL, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
